//--- rtl/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Bus widths shared by all three ports
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_ID_W 4

// Word counter in RegControl bits 23..13
`define DMA_COUNT_W 11

// Words buffered between reader and writer
`define DMA_FIFO_DEPTH 4

`endif

//--- rtl/obi_pkg.sv
`default_nettype none

`include "dma_macros.svh"

package obi_pkg;

  // Bus-side types, common to the slave port and both manager ports
  typedef logic [`DMA_ADDR_W-1:0] obi_addr_t;

  typedef logic [`DMA_DATA_W-1:0] obi_data_t;

  // One enable per byte lane
  typedef logic [`DMA_DATA_W/8-1:0] obi_be_t;

  typedef logic [`DMA_ID_W-1:0] obi_id_t;

endpackage

`default_nettype wire

//--- rtl/dma_reg_pkg.sv
`default_nettype none

`include "dma_macros.svh"

package dma_reg_pkg;

  typedef logic [`DMA_COUNT_W-1:0] dma_count_t;

  // Word-aligned offset inside the 256-byte register window
  typedef logic [7:0] dma_reg_addr_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam dma_reg_addr_t RegSrcAddr = 8'h00;
  localparam dma_reg_addr_t RegDstAddr = 8'h04;
  localparam dma_reg_addr_t RegControl = 8'h08;
  localparam dma_reg_addr_t RegAbort   = 8'h10;
  localparam dma_reg_addr_t RegStatus  = 8'h14;

  // Layout of RegControl
  typedef struct packed {
    logic [7:0]  reserved_hi;
    dma_count_t  count;
    logic [11:0] reserved_lo;
    logic        start;
  } dma_control_t;

endpackage

`default_nettype wire

//--- rtl/dma_cfg_if.sv
`default_nettype none

interface dma_cfg_if;

  obi_pkg::obi_addr_t      src_addr;
  obi_pkg::obi_addr_t      dst_addr;
  dma_reg_pkg::dma_count_t count;

  // Single-cycle pulses from the register file
  logic start;
  logic abort;

  // High while the writer has words left to store
  logic busy;

  modport regfile (output src_addr, dst_addr, count, start, abort, input busy);

  modport reader (input src_addr, dst_addr, count, start, abort);

  modport writer (input src_addr, dst_addr, count, start, abort, output busy);

endinterface

`default_nettype wire

//--- rtl/dma_regfile.sv
`default_nettype none

`include "dma_macros.svh"

module dma_regfile
  import obi_pkg::*;
  import dma_reg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       sbr_req_i,
  input  obi_addr_t  sbr_addr_i,
  input  logic       sbr_we_i,
  input  obi_data_t  sbr_wdata_i,
  input  obi_id_t    sbr_aid_i,
  output logic       sbr_gnt_o,
  output logic       sbr_rvalid_o,
  output obi_data_t  sbr_rdata_o,
  output logic       sbr_err_o,
  output obi_id_t    sbr_rid_o,

  dma_cfg_if.regfile cfg
);

  // --------------------------------------------------
  // Request stage
  // --------------------------------------------------
  logic          req_q;
  logic          we_q;
  dma_reg_addr_t offset_q;
  obi_data_t     wdata_q;
  obi_id_t       id_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= sbr_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    we_q     <= sbr_we_i;
    offset_q <= {sbr_addr_i[7:2], 2'b00};
    wdata_q  <= sbr_wdata_i;
    id_q     <= sbr_aid_i;
  end

  // --------------------------------------------------
  // Decode and response
  // --------------------------------------------------
  obi_addr_t    src_q;
  obi_addr_t    dst_q;
  dma_count_t   count_q;
  dma_control_t ctrl_wr;
  dma_control_t ctrl_rd;
  obi_data_t    rsp_data;
  logic         rsp_err;
  logic         wr_src;
  logic         wr_dst;
  logic         wr_ctrl;
  logic         wr_abort;

  assign ctrl_wr = dma_control_t'(wdata_q);

  always_comb begin
    rsp_data      = '0;
    rsp_err       = 1'b0;
    wr_src        = 1'b0;
    wr_dst        = 1'b0;
    wr_ctrl       = 1'b0;
    wr_abort      = 1'b0;
    ctrl_rd       = '0;
    ctrl_rd.count = count_q;
    if (req_q) begin
      if (we_q) begin
        // Only an abort gets through while a transfer runs
        if (cfg.busy && offset_q != RegAbort) begin
          rsp_err = 1'b1;
        end else begin
          case (offset_q)
            RegSrcAddr: wr_src = 1'b1;
            RegDstAddr: wr_dst = 1'b1;
            RegControl: wr_ctrl = 1'b1;
            RegAbort:   wr_abort = 1'b1;
            default:    rsp_err = 1'b1;
          endcase
        end
      end else begin
        case (offset_q)
          RegSrcAddr: rsp_data = src_q;
          RegDstAddr: rsp_data = dst_q;
          RegControl: rsp_data = ctrl_rd;
          RegStatus:  rsp_data = {{(`DMA_DATA_W-1){1'b0}}, cfg.busy};
          default:    rsp_err = 1'b1;
        endcase
      end
    end
  end

  // Setup registers change at the response edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
    end else begin
      if (wr_src) begin
        src_q <= wdata_q;
      end
      if (wr_dst) begin
        dst_q <= wdata_q;
      end
      if (wr_ctrl) begin
        count_q <= ctrl_wr.count;
      end
    end
  end

  assign sbr_gnt_o    = sbr_req_i;
  assign sbr_rvalid_o = req_q;
  assign sbr_rdata_o  = rsp_data;
  assign sbr_err_o    = rsp_err;
  assign sbr_rid_o    = id_q;

  assign cfg.src_addr = src_q;
  assign cfg.dst_addr = dst_q;
  assign cfg.count    = count_q;
  // A zero word count never starts the engines
  assign cfg.start    = wr_ctrl && ctrl_wr.start && (ctrl_wr.count != '0);
  assign cfg.abort    = wr_abort;

endmodule

`default_nettype wire

//--- rtl/dma_fifo.sv
`default_nettype none

`include "dma_macros.svh"

module dma_fifo
  import obi_pkg::*;
#(
  parameter int unsigned Depth = `DMA_FIFO_DEPTH
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,

  input  logic      push_i,
  input  obi_data_t push_data_i,
  output logic      full_o,

  input  logic      pop_i,
  output obi_data_t pop_data_o,
  output logic      empty_o
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  obi_data_t       mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push_en;
  logic            pop_en;

  // Pointers wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o     = (count_q == CntW'(Depth));
  assign empty_o    = (count_q == '0);
  assign push_en    = push_i && !full_o;
  assign pop_en     = pop_i && !empty_o;
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dma_reader.sv
`default_nettype none

module dma_reader
  import obi_pkg::*;
  import dma_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  dma_cfg_if.reader cfg,

  output logic      rd_req_o,
  output obi_addr_t rd_addr_o,
  input  logic      rd_gnt_i,
  input  logic      rd_rvalid_i,
  input  obi_data_t rd_rdata_i,

  output logic      fifo_push_o,
  output obi_data_t fifo_data_o,
  input  logic      fifo_full_i,
  output logic      fifo_flush_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_resp
  } rd_state_e;

  rd_state_e  state_q;
  dma_count_t cnt_q;
  dma_count_t cnt_next;
  obi_addr_t  addr_q;

  assign cnt_next = cnt_q + 1'b1;

  // A free slot stays free until the data returns, so req holds stable
  assign rd_req_o     = (state_q == st_req) && !fifo_full_i;
  assign rd_addr_o    = addr_q;
  assign fifo_push_o  = (state_q == st_resp) && rd_rvalid_i && !cfg.abort;
  assign fifo_data_o  = rd_rdata_i;
  assign fifo_flush_o = cfg.abort;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else if (cfg.abort) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (cfg.start) begin
            state_q <= st_req;
            cnt_q   <= '0;
          end
        end
        st_req: begin
          if (rd_req_o && rd_gnt_i) begin
            state_q <= st_resp;
          end
        end
        st_resp: begin
          if (rd_rvalid_i) begin
            cnt_q   <= cnt_next;
            state_q <= (cnt_next == cfg.count) ? st_idle : st_req;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Source address, one word further per returned word
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && cfg.start) begin
      addr_q <= cfg.src_addr;
    end else if (fifo_push_o) begin
      addr_q <= addr_q + obi_addr_t'(4);
    end
  end

endmodule

`default_nettype wire

//--- rtl/dma_writer.sv
`default_nettype none

module dma_writer
  import obi_pkg::*;
  import dma_reg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  dma_cfg_if.writer cfg,

  output logic      wr_req_o,
  output obi_addr_t wr_addr_o,
  output obi_data_t wr_wdata_o,
  input  logic      wr_gnt_i,

  output logic      fifo_pop_o,
  input  obi_data_t fifo_data_i,
  input  logic      fifo_empty_i
);

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_gnt
  } wr_state_e;

  wr_state_e  state_q;
  dma_count_t cnt_q;
  dma_count_t cnt_next;
  obi_addr_t  addr_q;
  obi_data_t  wdata_q;
  logic       granted;
  logic       last_gnt;

  assign cnt_next = cnt_q + 1'b1;
  assign granted  = (state_q == wr_gnt) && wr_gnt_i;
  assign last_gnt = granted && (cnt_next == cfg.count);

  // Pop on entry, or straight after a grant when more words remain
  assign fifo_pop_o = !cfg.abort && !fifo_empty_i &&
                      ((state_q == wr_data) || (granted && !last_gnt));

  assign wr_req_o   = (state_q == wr_gnt);
  assign wr_addr_o  = addr_q;
  assign wr_wdata_o = wdata_q;
  assign cfg.busy   = (state_q != wr_idle);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= wr_idle;
      cnt_q   <= '0;
    end else if (cfg.abort) begin
      state_q <= wr_idle;
    end else begin
      case (state_q)
        wr_idle: begin
          if (cfg.start) begin
            state_q <= wr_data;
            cnt_q   <= '0;
          end
        end
        wr_data: begin
          if (fifo_pop_o) begin
            state_q <= wr_gnt;
          end
        end
        wr_gnt: begin
          if (wr_gnt_i) begin
            cnt_q <= cnt_next;
            if (last_gnt) begin
              state_q <= wr_idle;
            end else if (fifo_empty_i) begin
              state_q <= wr_data;
            end
          end
        end
        default: state_q <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == wr_idle && cfg.start) begin
      addr_q <= cfg.dst_addr;
    end else if (granted) begin
      addr_q <= addr_q + obi_addr_t'(4);
    end
    if (fifo_pop_o) begin
      wdata_q <= fifo_data_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dma.sv
`default_nettype none

module dma
  import obi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Setup port from the CPU
  input  logic      sbr_req_i,
  input  obi_addr_t sbr_addr_i,
  input  logic      sbr_we_i,
  input  obi_data_t sbr_wdata_i,
  input  obi_id_t   sbr_aid_i,
  output logic      sbr_gnt_o,
  output logic      sbr_rvalid_o,
  output obi_data_t sbr_rdata_o,
  output logic      sbr_err_o,
  output obi_id_t   sbr_rid_o,

  // Source reads
  output logic      periph_req_o,
  output obi_addr_t periph_addr_o,
  output logic      periph_we_o,
  output obi_be_t   periph_be_o,
  output obi_data_t periph_wdata_o,
  input  logic      periph_gnt_i,
  input  logic      periph_rvalid_i,
  input  obi_data_t periph_rdata_i,

  // Destination writes; the write response carries nothing the writer needs
  output logic      xbar_req_o,
  output obi_addr_t xbar_addr_o,
  output logic      xbar_we_o,
  output obi_be_t   xbar_be_o,
  output obi_data_t xbar_wdata_o,
  input  logic      xbar_gnt_i,
  input  logic      xbar_rvalid_i
);

  dma_cfg_if cfg ();

  logic      fifo_push;
  obi_data_t fifo_push_data;
  logic      fifo_full;
  logic      fifo_flush;
  logic      fifo_pop;
  obi_data_t fifo_pop_data;
  logic      fifo_empty;

  // --------------------------------------------------
  // Port tie-offs, full words only
  // --------------------------------------------------
  assign periph_we_o    = 1'b0;
  assign periph_be_o    = '1;
  assign periph_wdata_o = '0;
  assign xbar_we_o      = 1'b1;
  assign xbar_be_o      = '1;

  dma_regfile u_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sbr_req_i    (sbr_req_i),
    .sbr_addr_i   (sbr_addr_i),
    .sbr_we_i     (sbr_we_i),
    .sbr_wdata_i  (sbr_wdata_i),
    .sbr_aid_i    (sbr_aid_i),
    .sbr_gnt_o    (sbr_gnt_o),
    .sbr_rvalid_o (sbr_rvalid_o),
    .sbr_rdata_o  (sbr_rdata_o),
    .sbr_err_o    (sbr_err_o),
    .sbr_rid_o    (sbr_rid_o),
    .cfg          (cfg.regfile)
  );

  dma_reader u_reader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg          (cfg.reader),
    .rd_req_o     (periph_req_o),
    .rd_addr_o    (periph_addr_o),
    .rd_gnt_i     (periph_gnt_i),
    .rd_rvalid_i  (periph_rvalid_i),
    .rd_rdata_i   (periph_rdata_i),
    .fifo_push_o  (fifo_push),
    .fifo_data_o  (fifo_push_data),
    .fifo_full_i  (fifo_full),
    .fifo_flush_o (fifo_flush)
  );

  dma_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (fifo_flush),
    .push_i      (fifo_push),
    .push_data_i (fifo_push_data),
    .full_o      (fifo_full),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_pop_data),
    .empty_o     (fifo_empty)
  );

  dma_writer u_writer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg          (cfg.writer),
    .wr_req_o     (xbar_req_o),
    .wr_addr_o    (xbar_addr_o),
    .wr_wdata_o   (xbar_wdata_o),
    .wr_gnt_i     (xbar_gnt_i),
    .fifo_pop_o   (fifo_pop),
    .fifo_data_i  (fifo_pop_data),
    .fifo_empty_i (fifo_empty)
  );

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
  parameter int Period      = 8,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_dma.sv
`default_nettype none

module tb_dma
  import obi_pkg::*;
  import dma_reg_pkg::*;
();

  localparam logic [31:0] Seed    = 32'h51bb_21a5;
  localparam obi_addr_t   RegBase = 32'h1A10_0000;
  // 50 words in all, about 40 cycles per word at worst, plus setup accesses
  localparam int TotalWords = 50;
  localparam int CycleLimit = TotalWords * 40 + 1000;

  typedef struct packed {
    obi_addr_t addr;
    obi_data_t data;
  } bus_write_t;

  logic      clk;
  logic      rst_n;
  logic      sbr_req_i;
  obi_addr_t sbr_addr_i;
  logic      sbr_we_i;
  obi_data_t sbr_wdata_i;
  obi_id_t   sbr_aid_i;
  logic      sbr_gnt_o;
  logic      sbr_rvalid_o;
  obi_data_t sbr_rdata_o;
  logic      sbr_err_o;
  obi_id_t   sbr_rid_o;
  logic      periph_req_o;
  obi_addr_t periph_addr_o;
  logic      periph_we_o;
  obi_be_t   periph_be_o;
  obi_data_t periph_wdata_o;
  logic      periph_gnt_i;
  logic      periph_rvalid_i;
  obi_data_t periph_rdata_i;
  logic      xbar_req_o;
  obi_addr_t xbar_addr_o;
  logic      xbar_we_o;
  obi_be_t   xbar_be_o;
  obi_data_t xbar_wdata_o;
  logic      xbar_gnt_i;
  logic      xbar_rvalid_i;

  // Source window 0x1000..0x1FFF
  obi_data_t  src_mem [1024];
  obi_addr_t  log_addr [$];
  obi_data_t  log_data [$];
  obi_addr_t  cur_src;
  obi_addr_t  cur_dst;
  dma_count_t cur_count;
  int         writes_seen = 0;
  logic       rand_delays = 1'b0;
  obi_id_t    next_aid = '0;

  tb_clkgen #(.Period(8), .ResetCycles(3)) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dma dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .sbr_req_i (sbr_req_i), .sbr_addr_i (sbr_addr_i), .sbr_we_i (sbr_we_i),
    .sbr_wdata_i (sbr_wdata_i), .sbr_aid_i (sbr_aid_i), .sbr_gnt_o (sbr_gnt_o),
    .sbr_rvalid_o (sbr_rvalid_o), .sbr_rdata_o (sbr_rdata_o), .sbr_err_o (sbr_err_o),
    .sbr_rid_o (sbr_rid_o),
    .periph_req_o (periph_req_o), .periph_addr_o (periph_addr_o),
    .periph_we_o (periph_we_o), .periph_be_o (periph_be_o),
    .periph_wdata_o (periph_wdata_o), .periph_gnt_i (periph_gnt_i),
    .periph_rvalid_i (periph_rvalid_i), .periph_rdata_i (periph_rdata_i),
    .xbar_req_o (xbar_req_o), .xbar_addr_o (xbar_addr_o), .xbar_we_o (xbar_we_o),
    .xbar_be_o (xbar_be_o), .xbar_wdata_o (xbar_wdata_o), .xbar_gnt_i (xbar_gnt_i),
    .xbar_rvalid_i (xbar_rvalid_i)
  );

  // --------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic obi_data_t src_pattern(input obi_addr_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  // Write k of a transfer lands at dst+4k with the source word at src+4k
  function automatic bus_write_t expected_write(input obi_addr_t src, input obi_addr_t dst,
                                                input int k);
    bus_write_t w;
    obi_addr_t  a;
    a = src + obi_addr_t'(4 * k);
    w.addr = dst + obi_addr_t'(4 * k);
    w.data = src_mem[a[11:2]];
    return w;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "test stopped");
  endtask

  task automatic check_data(input string name, input obi_data_t exp, input obi_data_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_addr(input string name, input obi_addr_t exp, input obi_addr_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_id(input string name, input obi_id_t exp, input obi_id_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "id mismatch");
    end
  endtask

  task automatic check_be(input string name, input obi_be_t exp, input obi_be_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "byte enable mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_count(input string name, input dma_count_t exp, input dma_count_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "count mismatch");
    end
  endtask

  // --------------------------------------------------
  // Slave port accesses
  // --------------------------------------------------
  // The response is due exactly one cycle after the grant
  task automatic capture_response(input obi_id_t aid, output obi_data_t rdata,
                                  output logic err);
    check_flag("sbr_rvalid_o", 1'b1, sbr_rvalid_o);
    rdata = sbr_rdata_o;
    err   = sbr_err_o;
    check_id("sbr_rid_o", aid, sbr_rid_o);
  endtask

  task automatic reg_access(input logic we, input dma_reg_addr_t offset,
                            input obi_data_t wdata, output obi_data_t rdata,
                            output logic err);
    obi_id_t aid;
    aid      = next_aid;
    next_aid = next_aid + 1'b1;
    @(negedge clk);
    sbr_req_i   = 1'b1;
    sbr_addr_i  = RegBase | obi_addr_t'(offset);
    sbr_we_i    = we;
    sbr_wdata_i = wdata;
    sbr_aid_i   = aid;
    @(posedge clk);
    check_flag("sbr_gnt_o", 1'b1, sbr_gnt_o);
    @(negedge clk);
    sbr_req_i = 1'b0;
    capture_response(aid, rdata, err);
  endtask

  task automatic reg_write(input dma_reg_addr_t offset, input obi_data_t wdata,
                           input logic exp_err);
    obi_data_t rdata;
    logic      err;
    reg_access(1'b1, offset, wdata, rdata, err);
    check_flag("sbr_err_o", exp_err, err);
    if (exp_err) begin
      check_data("sbr_rdata_o", '0, rdata);
    end
  endtask

  task automatic reg_read(input dma_reg_addr_t offset, input logic exp_err,
                          output obi_data_t rdata);
    logic err;
    reg_access(1'b0, offset, '0, rdata, err);
    check_flag("sbr_err_o", exp_err, err);
  endtask

  task automatic run_transfer(input obi_addr_t src, input obi_addr_t dst,
                              input dma_count_t count, input logic random);
    dma_control_t ctrl;
    cur_src     = src;
    cur_dst     = dst;
    cur_count   = count;
    writes_seen = 0;
    rand_delays = random;
    reg_write(RegSrcAddr, src, 1'b0);
    reg_write(RegDstAddr, dst, 1'b0);
    ctrl       = '0;
    ctrl.count = count;
    ctrl.start = 1'b1;
    reg_write(RegControl, obi_data_t'(ctrl), 1'b0);
  endtask

  // Poll STATUS until busy drops
  task automatic wait_idle();
    obi_data_t rdata;
    do reg_read(RegStatus, 1'b0, rdata); while (rdata[0]);
  endtask

  task automatic transfer_and_check(input obi_addr_t src, input obi_addr_t dst,
                                    input dma_count_t count, input logic random);
    run_transfer(src, dst, count, random);
    wait_idle();
    check_count("xbar write count", count, dma_count_t'(writes_seen));
  endtask

  // --------------------------------------------------
  // Memory models
  // --------------------------------------------------
  initial begin : src_model
    logic [31:0] rng;
    int          wait_cycles;
    obi_addr_t   addr;
    rng             = Seed;
    periph_gnt_i    = 1'b0;
    periph_rvalid_i = 1'b0;
    periph_rdata_i  = '0;
    forever begin
      @(negedge clk);
      if (periph_req_o) begin
        rng         = lcg_next(rng);
        wait_cycles = rand_delays ? int'(rng[17:16]) : 0;
        while (wait_cycles > 0 && periph_req_o) begin
          @(negedge clk);
          wait_cycles--;
        end
        // An abort may have withdrawn the request
        if (periph_req_o) begin
          addr = periph_addr_o;
          if (addr[31:12] != 20'h1 || addr[1:0] != 2'b00) begin
            abort_run($sformatf("Source read outside the source window at 0x%h", addr));
          end
          check_flag("periph_we_o", 1'b0, periph_we_o);
          check_be("periph_be_o", '1, periph_be_o);
          check_data("periph_wdata_o", '0, periph_wdata_o);
          periph_gnt_i = 1'b1;
          @(negedge clk);
          periph_gnt_i = 1'b0;
          rng          = lcg_next(rng);
          wait_cycles  = rand_delays ? 1 + int'(rng[23:16]) % 3 : 1;
          repeat (wait_cycles - 1) @(negedge clk);
          periph_rvalid_i = 1'b1;
          periph_rdata_i  = src_mem[addr[11:2]];
          @(negedge clk);
          periph_rvalid_i = 1'b0;
          periph_rdata_i  = '0;
        end
      end
    end
  end

  initial begin : dst_model
    logic [31:0] rng;
    int          wait_cycles;
    rng           = lcg_next(Seed);
    xbar_gnt_i    = 1'b0;
    xbar_rvalid_i = 1'b0;
    forever begin
      @(negedge clk);
      xbar_rvalid_i = xbar_gnt_i;
      xbar_gnt_i    = 1'b0;
      if (xbar_req_o) begin
        rng         = lcg_next(rng);
        wait_cycles = rand_delays ? int'(rng[17:16]) : 0;
        while (wait_cycles > 0 && xbar_req_o) begin
          @(negedge clk);
          xbar_rvalid_i = 1'b0;
          wait_cycles--;
        end
        if (xbar_req_o) begin
          check_flag("xbar_we_o", 1'b1, xbar_we_o);
          check_be("xbar_be_o", '1, xbar_be_o);
          xbar_gnt_i = 1'b1;
          log_addr.push_back(xbar_addr_o);
          log_data.push_back(xbar_wdata_o);
        end
      end
    end
  end

  // Each logged write against the reference
  initial begin : compare
    bus_write_t exp;
    obi_addr_t  a;
    obi_data_t  d;
    forever begin
      @(posedge clk);
      while (log_addr.size() > 0) begin
        a = log_addr.pop_front();
        d = log_data.pop_front();
        if (writes_seen >= int'(cur_count)) begin
          abort_run("More xbar writes than the programmed word count");
        end
        exp = expected_write(cur_src, cur_dst, writes_seen);
        check_addr("xbar_addr_o", exp.addr, a);
        check_data("xbar_wdata_o", exp.data, d);
        writes_seen++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DMA never went idle", cycles);
    $display("Errors found");
    $fatal(1, "cycle limit reached");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    obi_data_t    rdata;
    dma_control_t ctrl;
    int           held;
    sbr_req_i   = 1'b0;
    sbr_addr_i  = '0;
    sbr_we_i    = 1'b0;
    sbr_wdata_i = '0;
    sbr_aid_i   = '0;
    for (int i = 0; i < 1024; i++) begin
      src_mem[i] = src_pattern(32'h0000_1000 + obi_addr_t'(4 * i));
    end
    wait (rst_n === 1'b1);

    // Reset state and register readback
    reg_read(RegStatus, 1'b0, rdata);
    check_data("STATUS", '0, rdata);
    reg_write(RegSrcAddr, 32'hDEAD_BEE0, 1'b0);
    reg_read(RegSrcAddr, 1'b0, rdata);
    check_data("SRC_ADDR", 32'hDEAD_BEE0, rdata);
    reg_write(RegDstAddr, 32'h0000_8000, 1'b0);
    reg_read(RegDstAddr, 1'b0, rdata);
    check_data("DST_ADDR", 32'h0000_8000, rdata);
    ctrl       = '0;
    ctrl.count = dma_count_t'(7);
    reg_write(RegControl, obi_data_t'(ctrl), 1'b0);
    reg_read(RegControl, 1'b0, rdata);
    check_data("CONTROL", obi_data_t'(ctrl), rdata);

    // Unmapped offset
    reg_read(8'h1C, 1'b1, rdata);
    check_data("sbr_rdata_o", '0, rdata);
    reg_write(8'h1C, 32'h1234_5678, 1'b1);

    transfer_and_check(32'h0000_1000, 32'h0000_8000, dma_count_t'(12), 1'b0);
    transfer_and_check(32'h0000_1040, 32'h0000_9000, dma_count_t'(1), 1'b1);
    transfer_and_check(32'h0000_1100, 32'h0000_9100, dma_count_t'(5), 1'b1);
    transfer_and_check(32'h0000_1200, 32'h0000_9200, dma_count_t'(16), 1'b1);

    // Setup locked while busy, then abort
    run_transfer(32'h0000_1400, 32'h0000_A000, dma_count_t'(16), 1'b1);
    reg_write(RegSrcAddr, 32'h0000_1FF0, 1'b1);
    reg_read(RegSrcAddr, 1'b0, rdata);
    check_data("SRC_ADDR", 32'h0000_1400, rdata);
    reg_read(RegStatus, 1'b0, rdata);
    check_data("STATUS", 32'h0000_0001, rdata);
    reg_write(RegAbort, '0, 1'b0);
    reg_read(RegStatus, 1'b0, rdata);
    check_data("STATUS", '0, rdata);
    held = writes_seen;
    if (held >= 16) begin
      abort_run("Aborted transfer still wrote all 16 words");
    end
    repeat (30) @(negedge clk);
    check_count("xbar writes after abort", dma_count_t'(held), dma_count_t'(writes_seen));

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/obi_pkg.sv
rtl/dma_reg_pkg.sv
rtl/dma_cfg_if.sv
rtl/dma_regfile.sv
rtl/dma_fifo.sv
rtl/dma_reader.sv
rtl/dma_writer.sv
rtl/dma.sv
tb/tb_clkgen.sv
tb/tb_dma.sv

//--- run.sh
#!/usr/bin/env bash
# Build the DMA testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_dma -o tb_dma

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_dma
